//--- compile.f
dsz_cfg_pkg.sv
dsz_chan_pkg.sv
dsz_ar_dispatch.sv
dsz_read_slot.sv
dsz_slot_merge.sv
dsz_read_top.sv
dsz_read_props.sv
tb_dsz_read.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+100
TOP       ?= tb_dsz_read
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- tb_dsz_read.sv
// Narrow memory serves requests in arrival order; IDs stay below 16 and narrow beats are 4 bytes
`timescale 1ns/10ps

module tb_dsz_read;

  localparam int unsigned nr_slots    = 2;
  // About 70 beats over all tests, each given some 40 cycles of random stalls
  localparam int unsigned cycle_limit = 3000;

  // Expected wide beat where mask marks the lanes the burst filled
  typedef struct packed {
    logic [63:0] data;
    logic [63:0] mask;
    logic [1:0]  resp;
    logic        last;
  } exp_beat_t;

  logic                     clk_i;
  logic                     rst_ni;
  dsz_chan_pkg::ar_chan_t   s_ar_i;
  logic                     s_ar_valid_i;
  logic                     s_ar_ready_o;
  dsz_chan_pkg::si_r_chan_t s_r_o;
  logic                     s_r_valid_o;
  logic                     s_r_ready_i;
  dsz_chan_pkg::ar_chan_t   m_ar_o;
  logic                     m_ar_valid_o;
  logic                     m_ar_ready_i;
  dsz_chan_pkg::mi_r_chan_t m_r_i;
  logic                     m_r_valid_i;
  logic                     m_r_ready_o;

  exp_beat_t                exp_q [16][$];
  dsz_chan_pkg::ar_chan_t   exp_ar_q [16][$];
  dsz_chan_pkg::ar_chan_t   mem_q [$];
  exp_beat_t                want;
  dsz_chan_pkg::ar_chan_t   want_ar;
  logic [31:0]              drv_rnd;
  logic [31:0]              mem_addr;
  logic                     r_fired;
  int unsigned              beat_idx;
  int unsigned              cycles;
  int unsigned              data_errors;
  string                    test_name;

  dsz_read_top #(
    .nr_slots (nr_slots)
  ) uut (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Memory content is the word address folded with a fixed pattern
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {2'b00, addr[31:2]} ^ 32'hA5A5_0000;
  endfunction

  // Response code follows the address so the two lanes of a word differ
  function automatic logic [1:0] resp_code(input logic [31:0] addr);
    return addr[3:2];
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    data_errors++;
    $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
  endtask

  // ----------------------------------------
  // Expected narrow request and wide beats
  // ----------------------------------------

  task automatic expect_burst(input dsz_chan_pkg::ar_chan_t ar);
    dsz_chan_pkg::ar_chan_t nar;
    exp_beat_t              beat;
    logic [31:0]            a;
    logic                   down;
    down = (ar.size > 3'd2);
    nar  = ar;
    if (down) begin
      nar.size = 3'd2;
      nar.len  = 8'(2 * (int'(ar.len) + 1) - 1 - int'(ar.addr[2]));
    end
    exp_ar_q[ar.id].push_back(nar);
    beat = '0;
    for (int i = 0; i <= int'(nar.len); i++) begin
      a = (ar.addr & ~32'h3) + 32'(4 * i);
      if (a[2]) begin
        beat.data[63:32] = mem_word(a);
        beat.mask[63:32] = '1;
      end else begin
        beat.data[31:0] = mem_word(a);
        beat.mask[31:0] = '1;
      end
      beat.resp = resp_code(a);
      beat.last = (i == int'(nar.len));
      // Downsize waits for the high lane unless the burst ends
      if (!down || a[2] || beat.last) begin
        exp_q[ar.id].push_back(beat);
        beat = '0;
      end
    end
  endtask

  task automatic send_req(input logic [3:0] id, input logic [31:0] addr,
                          input logic [7:0] len, input logic [2:0] size);
    @(negedge clk_i);
    s_ar_i.id    = id;
    s_ar_i.addr  = addr;
    s_ar_i.len   = len;
    s_ar_i.size  = size;
    s_ar_i.burst = 2'b01;
    s_ar_valid_i = 1'b1;
    expect_burst(s_ar_i);
    @(posedge clk_i);
    while (!s_ar_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    s_ar_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    int unsigned pending;
    do begin
      @(negedge clk_i);
      pending = mem_q.size();
      for (int i = 0; i < 16; i++) begin
        pending += exp_q[i].size() + exp_ar_q[i].size();
      end
    end while (pending != 0);
  endtask

  // ----------------------------------------
  // Port monitors
  // ----------------------------------------

  always @(posedge clk_i) begin
    r_fired <= m_r_valid_i && m_r_ready_o;
    if (rst_ni && m_ar_valid_o && m_ar_ready_i) begin
      if (exp_ar_q[m_ar_o.id].size() == 0) begin
        data_errors++;
        $display("Error %s: narrow request for id %0d was never issued", test_name, m_ar_o.id);
      end else begin
        want_ar = exp_ar_q[m_ar_o.id].pop_front();
        assert (m_ar_o == want_ar)
        else report_mismatch("narrow request", 64'(want_ar), 64'(m_ar_o));
      end
      mem_q.push_back(m_ar_o);
    end
    if (rst_ni && s_r_valid_o && s_r_ready_i) begin
      if (exp_q[s_r_o.id].size() == 0) begin
        data_errors++;
        $display("Error %s: extra wide beat for id %0d", test_name, s_r_o.id);
      end else begin
        want = exp_q[s_r_o.id].pop_front();
        assert ((s_r_o.data.word & want.mask) == want.data)
        else report_mismatch("data", want.data, s_r_o.data.word & want.mask);
        assert (s_r_o.resp == want.resp)
        else report_mismatch("resp", 64'(want.resp), 64'(s_r_o.resp));
        assert (s_r_o.last == want.last)
        else report_mismatch("last", 64'(want.last), 64'(s_r_o.last));
      end
    end
  end

  // Narrow memory and random ready on both ports
  always @(negedge clk_i) begin
    if (rst_ni) begin
      drv_rnd      = xorshift(drv_rnd);
      s_r_ready_i  = drv_rnd[3];
      m_ar_ready_i = drv_rnd[7];
      if (r_fired) begin
        m_r_valid_i = 1'b0;
        beat_idx++;
        if (beat_idx > int'(mem_q[0].len)) begin
          mem_q.delete(0);
          beat_idx = 0;
        end
      end
      if (!m_r_valid_i && mem_q.size() != 0 && drv_rnd[11]) begin
        mem_addr    = (mem_q[0].addr & ~32'h3) + 32'(4 * beat_idx);
        m_r_i.id    = mem_q[0].id;
        m_r_i.data  = mem_word(mem_addr);
        m_r_i.resp  = resp_code(mem_addr);
        m_r_i.last  = (beat_idx == int'(mem_q[0].len));
        m_r_valid_i = 1'b1;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycles);
    $display("*** FAILED ***");
    $finish;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    s_ar_i       = '0;
    s_ar_valid_i = 1'b0;
    s_r_ready_i  = 1'b0;
    m_ar_ready_i = 1'b0;
    m_r_i        = '0;
    m_r_valid_i  = 1'b0;
    beat_idx     = 0;
    data_errors  = 0;
    drv_rnd      = 32'd82832;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    test_name = "passthrough";
    send_req(4'd0, 32'h0000_1000, 8'd3, 3'd2);
    send_req(4'd1, 32'h0000_2004, 8'd2, 3'd2);
    wait_drained();
    test_name = "aligned_downsize";
    send_req(4'd0, 32'h0000_3000, 8'd3, 3'd3);
    wait_drained();
    test_name = "unaligned_downsize";
    send_req(4'd1, 32'h0000_4004, 8'd2, 3'd3);
    wait_drained();
    // Third request shares slot 0 and waits for it
    test_name = "outstanding";
    send_req(4'd0, 32'h0000_5000, 8'd5, 3'd3);
    send_req(4'd1, 32'h0000_6004, 8'd3, 3'd3);
    send_req(4'd2, 32'h0000_7000, 8'd1, 3'd2);
    wait_drained();

    $display("Checks done: %0d data errors, %0d protocol errors",
             data_errors, uut.u_props.fail_count);
    if (data_errors == 0 && uut.u_props.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- dsz_read_props.sv
// Port protocol checks for the downsizer top; payloads are assumed driven from reset onwards
`timescale 1ns/10ps

module dsz_read_props (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     s_ar_ready_o,
  input dsz_chan_pkg::si_r_chan_t s_r_o,
  input logic                     s_r_valid_o,
  input logic                     s_r_ready_i,
  input dsz_chan_pkg::ar_chan_t   m_ar_o,
  input logic                     m_ar_valid_o,
  input logic                     m_ar_ready_i,
  input logic                     m_r_ready_o
);

  // Number of failed properties so far
  int unsigned fail_count = 0;

  // ----------------------------------------
  // Back-pressure
  // ----------------------------------------

  wide_r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    s_r_valid_o && !s_r_ready_i |=> s_r_valid_o && $stable(s_r_o))
  else begin
    fail_count++;
    $error("Wide read beat dropped or changed while stalled");
  end

  narrow_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    m_ar_valid_o && !m_ar_ready_i |=> m_ar_valid_o && $stable(m_ar_o))
  else begin
    fail_count++;
    $error("Narrow request dropped or changed while stalled");
  end

  // Idle ports right after reset release
  reset_values: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !m_ar_valid_o && !s_r_valid_o && !m_r_ready_o && s_ar_ready_o)
  else begin
    fail_count++;
    $error("Ports not idle in the first cycle after reset");
  end

endmodule

bind dsz_read_top dsz_read_props u_props (.*);

//--- dsz_read_top.sv
// Read-only downsizer top; nr_slots from 1 to 16, one burst in flight per ID residue
`timescale 1ns/10ps

module dsz_read_top #(
  parameter int unsigned nr_slots = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  dsz_chan_pkg::ar_chan_t   s_ar_i,
  input  logic                     s_ar_valid_i,
  output logic                     s_ar_ready_o,
  output dsz_chan_pkg::si_r_chan_t s_r_o,
  output logic                     s_r_valid_o,
  input  logic                     s_r_ready_i,
  output dsz_chan_pkg::ar_chan_t   m_ar_o,
  output logic                     m_ar_valid_o,
  input  logic                     m_ar_ready_i,
  input  dsz_chan_pkg::mi_r_chan_t m_r_i,
  input  logic                     m_r_valid_i,
  output logic                     m_r_ready_o
);

  logic [nr_slots-1:0]                     slot_ar_valid, slot_ar_ready;
  logic [nr_slots-1:0]                     slot_r_valid, slot_r_ready;
  dsz_chan_pkg::ar_chan_t   [nr_slots-1:0] slot_m_ar;
  logic [nr_slots-1:0]                     slot_m_ar_valid, slot_m_ar_ready;
  dsz_chan_pkg::si_r_chan_t [nr_slots-1:0] slot_s_r;
  logic [nr_slots-1:0]                     slot_s_r_valid, slot_s_r_ready;

  dsz_ar_dispatch #(
    .nr_slots (nr_slots)
  ) u_dispatch (
    .s_ar_valid_i    (s_ar_valid_i),
    .s_ar_id_i       (s_ar_i.id),
    .s_ar_ready_o    (s_ar_ready_o),
    .slot_ar_valid_o (slot_ar_valid),
    .slot_ar_ready_i (slot_ar_ready),
    .m_r_valid_i     (m_r_valid_i),
    .m_r_id_i        (m_r_i.id),
    .m_r_ready_o     (m_r_ready_o),
    .slot_r_valid_o  (slot_r_valid),
    .slot_r_ready_i  (slot_r_ready)
  );

  // ----------------------------------------
  // Read slots
  // ----------------------------------------

  for (genvar g = 0; g < nr_slots; g++) begin : g_slot
    dsz_read_slot u_slot (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .ar_i         (s_ar_i),
      .ar_valid_i   (slot_ar_valid[g]),
      .ar_ready_o   (slot_ar_ready[g]),
      .m_ar_o       (slot_m_ar[g]),
      .m_ar_valid_o (slot_m_ar_valid[g]),
      .m_ar_ready_i (slot_m_ar_ready[g]),
      .m_r_i        (m_r_i),
      .m_r_valid_i  (slot_r_valid[g]),
      .m_r_ready_o  (slot_r_ready[g]),
      .s_r_o        (slot_s_r[g]),
      .s_r_valid_o  (slot_s_r_valid[g]),
      .s_r_ready_i  (slot_s_r_ready[g])
    );
  end

  dsz_slot_merge #(
    .nr_slots (nr_slots)
  ) u_merge (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .slot_ar_i       (slot_m_ar),
    .slot_ar_valid_i (slot_m_ar_valid),
    .slot_ar_ready_o (slot_m_ar_ready),
    .m_ar_o          (m_ar_o),
    .m_ar_valid_o    (m_ar_valid_o),
    .m_ar_ready_i    (m_ar_ready_i),
    .slot_r_i        (slot_s_r),
    .slot_r_valid_i  (slot_s_r_valid),
    .slot_r_ready_o  (slot_s_r_ready),
    .s_r_o           (s_r_o),
    .s_r_valid_o     (s_r_valid_o),
    .s_r_ready_i     (s_r_ready_i)
  );

endmodule

//--- dsz_slot_merge.sv
// Slot valids must hold until their transfer, otherwise the locked choice goes stale
`timescale 1ns/10ps

module dsz_slot_merge #(
  parameter int unsigned nr_slots = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  dsz_chan_pkg::ar_chan_t   [nr_slots-1:0] slot_ar_i,
  input  logic                     [nr_slots-1:0] slot_ar_valid_i,
  output logic                     [nr_slots-1:0] slot_ar_ready_o,
  output dsz_chan_pkg::ar_chan_t                  m_ar_o,
  output logic                                   m_ar_valid_o,
  input  logic                                   m_ar_ready_i,
  input  dsz_chan_pkg::si_r_chan_t [nr_slots-1:0] slot_r_i,
  input  logic                     [nr_slots-1:0] slot_r_valid_i,
  output logic                     [nr_slots-1:0] slot_r_ready_o,
  output dsz_chan_pkg::si_r_chan_t                s_r_o,
  output logic                                   s_r_valid_o,
  input  logic                                   s_r_ready_i
);

  localparam int unsigned sel_w = (nr_slots > 1) ? $clog2(nr_slots) : 1;
  localparam int unsigned ch_ar = 0;
  localparam int unsigned ch_r  = 1;

  typedef logic [sel_w-1:0] sel_t;

  logic [1:0][nr_slots-1:0] req;
  logic [1:0]               port_ready;
  logic [1:0]               lock_q;
  sel_t [1:0]               sel, ptr_q, idx_q;

  // First requester at or after the pointer
  function automatic sel_t rr_pick(input logic [nr_slots-1:0] valid, input sel_t ptr);
    sel_t        pick;
    int unsigned cand;
    logic        found;
    pick  = ptr;
    found = 1'b0;
    for (int unsigned i = 0; i < nr_slots; i++) begin
      cand = (32'(ptr) + i) % nr_slots;
      if (!found && valid[cand]) begin
        pick  = sel_t'(cand);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  assign req[ch_ar]        = slot_ar_valid_i;
  assign req[ch_r]         = slot_r_valid_i;
  assign port_ready[ch_ar] = m_ar_ready_i;
  assign port_ready[ch_r]  = s_r_ready_i;

  always_comb begin
    for (int unsigned c = 0; c < 2; c++) begin
      sel[c] = lock_q[c] ? idx_q[c] : rr_pick(req[c], ptr_q[c]);
    end
  end

  // ----------------------------------------
  // Port muxes
  // ----------------------------------------

  always_comb begin
    m_ar_o                        = slot_ar_i[sel[ch_ar]];
    m_ar_valid_o                  = slot_ar_valid_i[sel[ch_ar]];
    slot_ar_ready_o               = '0;
    slot_ar_ready_o[sel[ch_ar]]   = m_ar_ready_i;
    s_r_o                         = slot_r_i[sel[ch_r]];
    s_r_valid_o                   = slot_r_valid_i[sel[ch_r]];
    slot_r_ready_o                = '0;
    slot_r_ready_o[sel[ch_r]]     = s_r_ready_i;
  end

  // Stalled choice is held, a transfer moves the pointer past the winner
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= '0;
      idx_q  <= '0;
      ptr_q  <= '0;
    end else begin
      for (int unsigned c = 0; c < 2; c++) begin
        lock_q[c] <= req[c][sel[c]] && !port_ready[c];
        idx_q[c]  <= sel[c];
        if (req[c][sel[c]] && port_ready[c]) begin
          ptr_q[c] <= sel_t'((32'(sel[c]) + 32'd1) % nr_slots);
        end
      end
    end
  end

endmodule

//--- dsz_read_slot.sv
// One read burst at a time; downsized length must fit in 256 narrow beats, all bursts are INCR
`timescale 1ns/10ps

module dsz_read_slot (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  dsz_chan_pkg::ar_chan_t   ar_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  output dsz_chan_pkg::ar_chan_t   m_ar_o,
  output logic                    m_ar_valid_o,
  input  logic                    m_ar_ready_i,
  input  dsz_chan_pkg::mi_r_chan_t m_r_i,
  input  logic                    m_r_valid_i,
  output logic                    m_r_ready_o,
  output dsz_chan_pkg::si_r_chan_t s_r_o,
  output logic                    s_r_valid_o,
  input  logic                    s_r_ready_i
);

  localparam int unsigned lane_bits = dsz_cfg_pkg::lane_bits;
  localparam int unsigned len_w     = dsz_cfg_pkg::len_width;
  localparam int unsigned cnt_w     = $clog2(dsz_cfg_pkg::max_narrow_len + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_pass,
    st_down
  } state_e;

  state_e                   state_q, state_d;
  dsz_chan_pkg::ar_chan_t   ar_q, ar_d;
  logic                     ar_valid_q, ar_valid_d;
  dsz_chan_pkg::si_r_chan_t r_q, r_d;
  logic                     r_valid_q, r_valid_d;
  logic [cnt_w-1:0]         remaining_q, remaining_d;
  dsz_chan_pkg::addr_t      addr_q, addr_d;

  logic [len_w+lane_bits-1:0] full_len;
  dsz_chan_pkg::len_t         narrow_len;
  logic [lane_bits-1:0]       lane;
  dsz_chan_pkg::addr_t        step;

  // ----------------------------------------
  // Request conversion
  // ----------------------------------------

  // (len + 1) * ratio - 1, less the lanes skipped by an unaligned start
  assign full_len = {ar_i.len, {lane_bits{1'b1}}}
                  - (len_w + lane_bits)'(ar_i.addr[dsz_cfg_pkg::mi_size +: lane_bits]);
  assign narrow_len = full_len[len_w-1:0];

  // Lane of the next narrow beat and the address step per beat
  assign lane = addr_q[dsz_cfg_pkg::mi_size +: lane_bits];
  assign step = dsz_chan_pkg::addr_t'(1) << ar_q.size;

  // ----------------------------------------
  // Slot FSM
  // ----------------------------------------

  always_comb begin
    state_d     = state_q;
    ar_d        = ar_q;
    ar_valid_d  = ar_valid_q;
    r_d         = r_q;
    r_valid_d   = r_valid_q;
    remaining_d = remaining_q;
    addr_d      = addr_q;

    ar_ready_o  = (state_q == st_idle);
    // Hold off narrow beats while a wide beat waits, or before the request went out
    m_r_ready_o = (state_q != st_idle) && !ar_valid_q && (!r_valid_q || s_r_ready_i);

    if (ar_valid_q && m_ar_ready_i) begin
      ar_valid_d = 1'b0;
    end

    if (r_valid_q && s_r_ready_i) begin
      r_valid_d = 1'b0;
      if (r_q.last) begin
        state_d = st_idle;
      end
    end

    case (state_q)
      st_idle: begin
        if (ar_valid_i) begin
          ar_d        = ar_i;
          ar_valid_d  = 1'b1;
          addr_d      = ar_i.addr;
          remaining_d = ar_i.len;
          state_d     = st_pass;
          // Wider than a narrow beat, so split into full narrow beats
          if (ar_i.size > 3'(dsz_cfg_pkg::mi_size)) begin
            ar_d.size   = 3'(dsz_cfg_pkg::mi_size);
            ar_d.len    = narrow_len;
            remaining_d = narrow_len;
            state_d     = st_down;
          end
        end
      end
      default: begin
        if (m_r_valid_i && m_r_ready_o) begin
          r_d.data.lanes[lane] = m_r_i.data;
          r_d.id               = m_r_i.id;
          r_d.resp             = m_r_i.resp;
          r_d.last             = (remaining_q == '0);
          remaining_d          = remaining_q - 1'b1;
          addr_d               = (addr_q & ~(step - 1'b1)) + step;
          // Downsize emits once the top lane is filled or the burst ends
          if (state_q == st_pass || (&lane) || remaining_q == '0) begin
            r_valid_d = 1'b1;
          end
        end
      end
    endcase
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= st_idle;
      ar_valid_q  <= 1'b0;
      r_valid_q   <= 1'b0;
      remaining_q <= '0;
    end else begin
      state_q     <= state_d;
      ar_valid_q  <= ar_valid_d;
      r_valid_q   <= r_valid_d;
      remaining_q <= remaining_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ar_q   <= ar_d;
    r_q    <= r_d;
    addr_q <= addr_d;
  end

  assign m_ar_o       = ar_q;
  assign m_ar_valid_o = ar_valid_q;
  assign s_r_o        = r_q;
  assign s_r_valid_o  = r_valid_q;

endmodule

//--- dsz_ar_dispatch.sv
// Slot of a request or narrow beat is its ID modulo nr_slots; payloads go to every slot unchanged
`timescale 1ns/10ps

module dsz_ar_dispatch #(
  parameter int unsigned nr_slots = 2
) (
  input  logic                    s_ar_valid_i,
  input  dsz_chan_pkg::id_t       s_ar_id_i,
  output logic                    s_ar_ready_o,
  output logic [nr_slots-1:0]     slot_ar_valid_o,
  input  logic [nr_slots-1:0]     slot_ar_ready_i,
  input  logic                    m_r_valid_i,
  input  dsz_chan_pkg::id_t       m_r_id_i,
  output logic                    m_r_ready_o,
  output logic [nr_slots-1:0]     slot_r_valid_o,
  input  logic [nr_slots-1:0]     slot_r_ready_i
);

  localparam int unsigned sel_w = (nr_slots > 1) ? $clog2(nr_slots) : 1;

  typedef logic [sel_w-1:0] sel_t;

  sel_t ar_sel;
  sel_t r_sel;

  assign ar_sel = sel_t'(s_ar_id_i % nr_slots);
  assign r_sel  = sel_t'(m_r_id_i % nr_slots);

  // One-hot valid towards the owning slot
  always_comb begin
    slot_ar_valid_o         = '0;
    slot_ar_valid_o[ar_sel] = s_ar_valid_i;
    slot_r_valid_o          = '0;
    slot_r_valid_o[r_sel]   = m_r_valid_i;
  end

  // Ready comes back from the same slot
  assign s_ar_ready_o = slot_ar_ready_i[ar_sel];
  assign m_r_ready_o  = slot_r_ready_i[r_sel];

endmodule

//--- dsz_chan_pkg.sv
// Read channel payloads; valid and ready are separate wires, only INCR bursts are meaningful
package dsz_chan_pkg;

  // ----------------------------------------
  // Field types
  // ----------------------------------------

  typedef logic [dsz_cfg_pkg::addr_width-1:0]    addr_t;
  typedef logic [dsz_cfg_pkg::id_width-1:0]      id_t;
  typedef logic [dsz_cfg_pkg::len_width-1:0]     len_t;
  typedef logic [2:0]                            size_t;
  typedef logic [1:0]                            burst_t;
  typedef logic [1:0]                            resp_t;
  typedef logic [dsz_cfg_pkg::mi_data_width-1:0] mi_data_t;

  // ----------------------------------------
  // Channels
  // ----------------------------------------

  // Read request, same layout on both ports
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } ar_chan_t;

  // Wide word, seen whole or as narrow lanes (lane 0 is the low word)
  typedef union packed {
    logic [dsz_cfg_pkg::si_data_width-1:0] word;
    mi_data_t [dsz_cfg_pkg::ratio-1:0]     lanes;
  } si_word_u;

  // Wide read response
  typedef struct packed {
    id_t      id;
    si_word_u data;
    resp_t    resp;
    logic     last;
  } si_r_chan_t;

  // Narrow read response
  typedef struct packed {
    id_t      id;
    mi_data_t data;
    resp_t    resp;
    logic     last;
  } mi_r_chan_t;

endpackage

//--- dsz_cfg_pkg.sv
// Bus geometry for the read downsizer; the wide bus must be a power-of-two multiple of the narrow bus
package dsz_cfg_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------

  localparam int unsigned addr_width    = 32;
  localparam int unsigned id_width      = 4;
  localparam int unsigned si_data_width = 64;
  localparam int unsigned mi_data_width = 32;

  // Burst length field, same on both ports
  localparam int unsigned len_width     = 8;

  // ----------------------------------------
  // Derived values
  // ----------------------------------------

  localparam int unsigned si_bytes = si_data_width / 8;
  localparam int unsigned mi_bytes = mi_data_width / 8;

  // Size code of a full narrow beat, also the lowest lane address bit
  localparam int unsigned mi_size = $clog2(mi_bytes);

  // Narrow lanes per wide word
  localparam int unsigned ratio = si_bytes / mi_bytes;

  // Address bits that pick a lane inside the wide word
  localparam int unsigned lane_bits = $clog2(ratio);

  // Longest narrow burst, as a len field value
  localparam int unsigned max_narrow_len = (1 << len_width) - 1;

endpackage
